// ==== cpu_isa_pkg.sv ====
package cpu_isa_pkg;

  ////////////////////
  // Widths and sizes
  ////////////////////

  localparam int word_w     = 8;    // Data and instruction width
  localparam int reg_addr_w = 2;    // Register index width
  localparam int num_regs   = 4;
  localparam int opcode_w   = 4;
  localparam int imm_w      = 4;    // Immediate of op_li
  localparam int imem_depth = 256;
  localparam int dmem_depth = 256;

  // Field positions inside an instruction word
  localparam int opcode_lsb = 4;    // Bits 7..4
  localparam int rd_lsb     = 2;    // Bits 3..2
  localparam int rs_lsb     = 0;    // Bits 1..0

  ////////////////////
  // Opcodes
  ////////////////////

  // Codes 8 and 9 are unassigned and run as no-ops
  typedef enum logic [opcode_w-1:0] {
    op_halt = 4'd0,
    op_add  = 4'd1,
    op_sub  = 4'd2,
    op_and  = 4'd3,
    op_or   = 4'd4,
    op_xor  = 4'd5,
    op_li   = 4'd6,                 // r0 = zero-extended imm
    op_mov  = 4'd7,
    op_lw   = 4'd10,                // rd = mem[rs]
    op_sw   = 4'd11,                // mem[rs] = rd
    op_beq  = 4'd12,
    op_bne  = 4'd13,
    op_jmp  = 4'd14,
    op_out  = 4'd15                 // Send rd on the output port
  } opcode_e;

endpackage

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

  ////////////////////
  // Core phases
  ////////////////////

  localparam int phase_w = 4;

  // One clocked state per instruction phase
  typedef enum logic [phase_w-1:0] {
    ph_idle,                        // After reset, waits for start
    ph_fetch,
    ph_decode,                      // Instruction word arrives
    ph_read,
    ph_execute,                     // Holds here for the output handshake
    ph_memory,
    ph_writeback,
    ph_pc_update,
    ph_halted
  } phase_e;

  // Register file write source
  typedef enum logic {
    wsrc_alu,
    wsrc_mem
  } wsrc_e;

endpackage

// ==== instruction_mem.sv ====
`timescale 1ns/100ps

module instruction_mem
  import cpu_isa_pkg::*;
(
  input  logic              clk,
  input  logic              load_en,
  input  logic [word_w-1:0] load_addr,
  input  logic [word_w-1:0] load_data,
  input  logic              rd_en,
  input  logic [word_w-1:0] addr,
  output logic [word_w-1:0] data
);

  logic [word_w-1:0] mem [imem_depth];

  // Program load port
  always_ff @(posedge clk)
  begin
    if (load_en)
    begin
      mem[load_addr] <= load_data;
    end
  end

  // Registered read, word shows up one cycle after rd_en
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      data <= mem[addr];
    end
  end

endmodule

// ==== control_unit.sv ====
`timescale 1ns/100ps

module control_unit
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic [word_w-1:0]     instruction,
  output opcode_e               opcode,
  output logic [reg_addr_w-1:0] rd_addr,
  output logic [reg_addr_w-1:0] rs_addr,
  output logic                  reg_w_en,
  output logic                  mem_w_en,
  output logic                  mem_r_en,
  output logic                  is_out,
  output logic                  is_branch,
  output wsrc_e                 wsrc
);

  assign opcode  = opcode_e'(instruction[opcode_lsb +: opcode_w]);
  assign rs_addr = instruction[rs_lsb +: reg_addr_w];

  // op_li always targets r0
  assign rd_addr = (opcode == op_li) ? '0 : instruction[rd_lsb +: reg_addr_w];

  always_comb
  begin
    reg_w_en  = 1'b0;
    mem_w_en  = 1'b0;
    mem_r_en  = 1'b0;
    is_out    = 1'b0;
    is_branch = 1'b0;
    wsrc      = wsrc_alu;
    case (opcode)
      op_add, op_sub, op_and, op_or, op_xor, op_li, op_mov:
      begin
        reg_w_en = 1'b1;
      end
      op_lw:
      begin
        reg_w_en = 1'b1;
        mem_r_en = 1'b1;
        wsrc     = wsrc_mem;    // Load result comes from data memory
      end
      op_sw:
      begin
        mem_w_en = 1'b1;
      end
      op_beq, op_bne, op_jmp:
      begin
        is_branch = 1'b1;
      end
      op_out:
      begin
        is_out = 1'b1;
      end
      default:
      begin
        // op_halt and unassigned codes drive no enables
      end
    endcase
  end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu
  import cpu_isa_pkg::*;
(
  input  opcode_e           opcode,
  input  logic [word_w-1:0] op_a,      // rd value
  input  logic [word_w-1:0] op_b,      // rs value
  input  logic [imm_w-1:0]  imm,
  output logic [word_w-1:0] result,
  output logic              branch_taken
);

  ////////////////////
  // Result
  ////////////////////

  always_comb
  begin
    case (opcode)
      op_add:  result = op_a + op_b;    // Wraps modulo 256
      op_sub:  result = op_a - op_b;
      op_and:  result = op_a & op_b;
      op_or:   result = op_a | op_b;
      op_xor:  result = op_a ^ op_b;
      op_mov:  result = op_b;
      op_li:   result = {{(word_w-imm_w){1'b0}}, imm};
      default: result = '0;
    endcase
  end

  ////////////////////
  // Branch decision
  ////////////////////

  always_comb
  begin
    case (opcode)
      op_beq:
      begin
        branch_taken = (op_a == op_b);
      end
      op_bne:
      begin
        branch_taken = (op_a != op_b);
      end
      op_jmp:
      begin
        branch_taken = 1'b1;            // Unconditional
      end
      default:
      begin
        branch_taken = 1'b0;
      end
    endcase
  end

endmodule

// ==== data_mem.sv ====
`timescale 1ns/100ps

module data_mem
  import cpu_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [word_w-1:0] addr,
  input  logic [word_w-1:0] wr_data,
  input  logic              wr_en,
  input  logic              rd_en,
  output logic [word_w-1:0] rd_data
);

  logic [word_w-1:0] mem [dmem_depth];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[addr] <= wr_data;
    end
  end

  // Read in ph_memory, data valid in ph_writeback
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_data <= '0;
    end
    else if (rd_en)
    begin
      rd_data <= mem[addr];
    end
  end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  output logic [word_w-1:0] imem_addr,
  output logic              imem_rd_en,
  input  logic [word_w-1:0] imem_data,
  output logic [word_w-1:0] dmem_addr,
  output logic [word_w-1:0] dmem_wr_data,
  output logic              dmem_wr_en,
  output logic              dmem_rd_en,
  input  logic [word_w-1:0] dmem_rd_data,
  output logic              out_valid,
  input  logic              out_ready,
  output logic [word_w-1:0] out_data,
  output logic              halted,
  output logic              idle
);

  phase_e                phase;
  logic [word_w-1:0]     pc;
  logic [word_w-1:0]     ir;              // Instruction register
  logic [word_w-1:0]     op_a;            // rd value
  logic [word_w-1:0]     op_b;            // rs value
  logic [word_w-1:0]     offset;          // r0, branch offset
  logic [word_w-1:0]     rf [num_regs];
  logic [word_w-1:0]     wb_data;

  opcode_e               opcode;
  logic [reg_addr_w-1:0] rd_addr;
  logic [reg_addr_w-1:0] rs_addr;
  logic                  reg_w_en;
  logic                  mem_w_en;
  logic                  mem_r_en;
  logic                  is_out;
  logic                  is_branch;
  wsrc_e                 wsrc;
  logic [word_w-1:0]     alu_result;
  logic                  branch_taken;
  logic                  fetched_halt;

  control_unit u_ctrl (
    .instruction (ir),
    .opcode      (opcode),
    .rd_addr     (rd_addr),
    .rs_addr     (rs_addr),
    .reg_w_en    (reg_w_en),
    .mem_w_en    (mem_w_en),
    .mem_r_en    (mem_r_en),
    .is_out      (is_out),
    .is_branch   (is_branch),
    .wsrc        (wsrc)
  );

  alu u_alu (
    .opcode       (opcode),
    .op_a         (op_a),
    .op_b         (op_b),
    .imm          (ir[imm_w-1:0]),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  // Halt is seen on the raw word, before ir holds it
  assign fetched_halt = (opcode_e'(imem_data[opcode_lsb +: opcode_w]) == op_halt);
  assign wb_data      = (wsrc == wsrc_mem) ? dmem_rd_data : alu_result;

  ////////////////////
  // Phase FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase <= ph_idle;
      pc    <= '0;
      ir    <= '0;
      for (int i = 0; i < num_regs; i++)
      begin
        rf[i] <= '0;
      end
    end
    else
    begin
      case (phase)
        ph_idle, ph_halted:
        begin
          if (start)
          begin
            pc    <= '0;                 // Registers and data memory keep contents
            phase <= ph_fetch;
          end
        end
        ph_fetch:      phase <= ph_decode;
        ph_decode:
        begin
          ir    <= imem_data;
          phase <= fetched_halt ? ph_halted : ph_read;
        end
        ph_read:       phase <= ph_execute;
        ph_execute:
        begin
          if (!is_out || out_ready)      // Stall on output back-pressure
          begin
            phase <= ph_memory;
          end
        end
        ph_memory:     phase <= ph_writeback;
        ph_writeback:
        begin
          if (reg_w_en)
          begin
            rf[rd_addr] <= wb_data;
          end
          phase <= ph_pc_update;
        end
        ph_pc_update:
        begin
          pc    <= pc + 8'd1 + ((is_branch && branch_taken) ? offset : '0);
          phase <= ph_fetch;
        end
        default:       phase <= ph_idle;
      endcase
    end
  end

  // Operand latch
  always_ff @(posedge clk)
  begin
    if (phase == ph_read)
    begin
      op_a   <= rf[rd_addr];
      op_b   <= rf[rs_addr];
      offset <= rf[0];
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign imem_addr    = pc;
  assign imem_rd_en   = (phase == ph_fetch);
  assign dmem_addr    = op_b;                // Address through rs
  assign dmem_wr_data = op_a;
  assign dmem_wr_en   = (phase == ph_memory) && mem_w_en;
  assign dmem_rd_en   = (phase == ph_memory) && mem_r_en;
  assign out_valid    = (phase == ph_execute) && is_out;
  assign out_data     = op_a;
  assign halted       = (phase == ph_halted);
  assign idle         = (phase == ph_idle);

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic       load_valid,
  output logic       load_ready,
  input  logic [7:0] load_addr,
  input  logic [7:0] load_data,
  output logic       out_valid,
  input  logic       out_ready,
  output logic [7:0] out_data,
  output logic       halted
);

  logic [7:0] imem_addr;
  logic       imem_rd_en;
  logic [7:0] imem_data;
  logic [7:0] dmem_addr;
  logic [7:0] dmem_wr_data;
  logic       dmem_wr_en;
  logic       dmem_rd_en;
  logic [7:0] dmem_rd_data;
  logic       idle;

  // Loading only while no program runs
  assign load_ready = idle | halted;

  cpu_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .imem_addr    (imem_addr),
    .imem_rd_en   (imem_rd_en),
    .imem_data    (imem_data),
    .dmem_addr    (dmem_addr),
    .dmem_wr_data (dmem_wr_data),
    .dmem_wr_en   (dmem_wr_en),
    .dmem_rd_en   (dmem_rd_en),
    .dmem_rd_data (dmem_rd_data),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .halted       (halted),
    .idle         (idle)
  );

  instruction_mem u_imem (
    .clk       (clk),
    .load_en   (load_valid & load_ready),
    .load_addr (load_addr),
    .load_data (load_data),
    .rd_en     (imem_rd_en),
    .addr      (imem_addr),
    .data      (imem_data)
  );

  data_mem u_dmem (
    .clk     (clk),
    .rst_n   (rst_n),
    .addr    (dmem_addr),
    .wr_data (dmem_wr_data),
    .wr_en   (dmem_wr_en),
    .rd_en   (dmem_rd_en),
    .rd_data (dmem_rd_data)
  );

endmodule

// ==== cpu_props.sv ====
`timescale 1ns/100ps

module cpu_props
  import cpu_ctrl_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       start,
  input phase_e     phase,
  input logic       out_valid,
  input logic       out_ready,
  input logic [7:0] out_data
);

  int unsigned fail_count = 0;            // Assertion failures so far

  // Output held while the consumer stalls
  out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
  else
  begin
    $error("out_data or out_valid changed during a stall");
    fail_count++;
  end

  // A transfer ends ph_execute, so no byte goes out twice
  out_phase_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |=> !out_valid && phase == ph_memory)
  else
  begin
    $error("core did not leave ph_execute after an output transfer");
    fail_count++;
  end

  // Only start leaves the halted state
  halt_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    phase == ph_halted && !start |=> phase == ph_halted)
  else
  begin
    $error("phase left ph_halted without start");
    fail_count++;
  end

endmodule

// ==== cpu_tb.sv ====
`timescale 1ns/100ps

module cpu_tb;

  localparam int num_rows   = 5;
  localparam int prog_words = 16;
  localparam int max_outs   = 8;
  localparam int clk_period = 10;
  localparam int timeout_ns = num_rows * prog_words * 7 * 4 * clk_period;

  logic       clk;
  logic       rst_n;
  logic       start;
  logic       load_valid;
  logic       load_ready;
  logic [7:0] load_addr;
  logic [7:0] load_data;
  logic       out_valid;
  logic       out_ready;
  logic [7:0] out_data;
  logic       halted;

  integer     seed;
  logic [7:0] got [$];                            // Bytes accepted on the output port

  // Program words and expected bytes with the first one in the MSBs
  logic [prog_words*8-1:0] prog_tbl [num_rows];
  logic [max_outs*8-1:0]   exp_tbl  [num_rows];
  int                      cnt_tbl  [num_rows];

  cpu_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .halted     (halted)
  );

  bind cpu_core cpu_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .phase     (phase),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #(clk_period / 2) clk = ~clk;

  // Random back-pressure on the output port
  always @(posedge clk)
  begin
    #1;
    out_ready = ($random(seed) & 1) != 0;
  end

  // Transfer happens on the next rising edge
  always @(negedge clk)
  begin
    if (rst_n && out_valid && out_ready)
    begin
      got.push_back(out_data);
    end
  end

  initial
  begin
    #(timeout_ns);
    $display("Timeout: programs did not halt within %0d ns", timeout_ns);
    $display("test failed");
    $fatal(1, "Simulation timeout");
  end

  // Stop at the first failed assertion in the core
  always @(dut_i.u_core.props_i.fail_count)
  begin
    if (dut_i.u_core.props_i.fail_count != 0)
    begin
      $display("Assertion failure in the core at %0t ns", $time);
      $display("test failed");
      $fatal(1, "Assertion failure");
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  task fill_table;
    // ALU ops with wrap in sub and add
    prog_tbl[0] = 128'h69_74_6f_78_16_f4_29_f8_1a_f8_39_f8_48_59_f8_00;
    exp_tbl[0]  = 64'h18_f7_ee_08_17_00_00_00;
    cnt_tbl[0]  = 5;
    // Store and load through r3 and r0
    prog_tbl[1] = 128'h65_7c_6c_78_bb_63_78_b8_a7_f4_ac_fc_00_00_00_00;
    exp_tbl[1]  = 64'h0c_03_00_00_00_00_00_00;
    cnt_tbl[1]  = 2;
    // beq and bne, taken and not taken
    prog_tbl[2] = 128'h61_74_78_c6_f4_d6_f4_62_78_d6_f8_f4_c6_f8_00_00;
    exp_tbl[2]  = 64'h01_02_00_00_00_00_00_00;
    cnt_tbl[2]  = 2;
    // jmp over one word, then countdown from 3 with bne
    prog_tbl[3] = 128'h63_74_61_78_e0_f8_60_7c_21_f4_26_d7_00_00_00_00;
    exp_tbl[3]  = 64'h03_02_01_00_00_00_00_00;
    cnt_tbl[3]  = 3;
    // Restart with registers and data memory kept from earlier rows
    prog_tbl[4] = 128'hf0_f4_f8_fc_65_a4_f4_00_00_00_00_00_00_00_00_00;
    exp_tbl[4]  = 64'hfd_00_01_00_0c_00_00_00;
    cnt_tbl[4]  = 5;
  endtask

  task load_program(input int row);
    for (int i = 0; i < prog_words; i++)
    begin
      load_valid = 1'b1;
      load_addr  = 8'(i);
      load_data  = prog_tbl[row][(prog_words - 1 - i) * 8 +: 8];
      @(negedge clk);
      while (!load_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    load_valid = 1'b0;
  endtask

  task pulse_start;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task run_row(input int row);
    got.delete();
    load_program(row);
    pulse_start();
    @(negedge clk);
    check_value(halted, 1'b0, $sformatf("row %0d halted after start", row));
    check_value(load_ready, 1'b0, $sformatf("row %0d load_ready while running", row));
    while (!halted) @(negedge clk);
    check_value(load_ready, 1'b1, $sformatf("row %0d load_ready after halt", row));
    check_value(got.size(), cnt_tbl[row], $sformatf("row %0d output count", row));
    for (int i = 0; i < cnt_tbl[row]; i++)
    begin
      check_value(got[i], exp_tbl[row][(max_outs - 1 - i) * 8 +: 8],
                  $sformatf("row %0d output %0d", row, i));
    end
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    seed       = 32'hb0d2_49b9;
    clk        = 1'b0;
    rst_n      = 1'b0;
    start      = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    out_ready  = 1'b0;
    fill_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value(load_ready, 1'b1, "load_ready after reset");
    check_value(halted, 1'b0, "halted after reset");
    check_value(out_valid, 1'b0, "out_valid after reset");
    @(posedge clk);
    #1;
    for (int row = 0; row < num_rows; row++)
    begin
      run_row(row);
    end
    $display("test passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
cpu_isa_pkg.sv
cpu_ctrl_pkg.sv
instruction_mem.sv
control_unit.sv
alu.sv
data_mem.sv
cpu_core.sv
cpu_top.sv
cpu_props.sv
cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mc_cpu

sources:
  - cpu_isa_pkg.sv
  - cpu_ctrl_pkg.sv
  - instruction_mem.sv
  - control_unit.sv
  - alu.sv
  - data_mem.sv
  - cpu_core.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_props.sv
      - cpu_tb.sv
